// File: list.f
verilog/swj_pkg.sv
verilog/swj_byte_packer.sv
verilog/swj_resp_writer.sv
verilog/swj_cmd_ctrl.sv
verilog/swj_cmd_top.sv
tests/tb_swj_cmd.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
TOP       := tb_swj_cmd
FILELIST  := list.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := STATUS: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_swj_cmd.sv
`timescale 1ns/10ps

module tb_swj_cmd;
    import swj_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    typedef struct packed {
        logic [3:0] op;
        bit_len_t   len;
        word64_t    data;
    } chunk_t;

    logic      clk;
    logic      resetn;
    cmd_vec_t  start;
    logic      dap_in_valid;
    byte_t     dap_in_data;
    cmd_vec_t  dap_in_ready;
    seq_req_t  seq_req;
    seq_rsp_t  seq_rsp;
    ram_wr_t   ram_wr;
    ram_addr_t packet_len;
    cmd_vec_t  done;

    integer seed = 32'hc554;
    int     errors = 0;
    chunk_t exp_req_q[$];
    byte_t  exp_ram_q[$];
    byte_t  pins_reply;   // readback byte the model returns for pins

    swj_cmd_top dut_i (
        .clk          (clk),
        .resetn       (resetn),
        .start        (start),
        .dap_in_valid (dap_in_valid),
        .dap_in_data  (dap_in_data),
        .dap_in_ready (dap_in_ready),
        .seq_req      (seq_req),
        .seq_rsp      (seq_rsp),
        .ram_wr       (ram_wr),
        .packet_len   (packet_len),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic word64_t len_mask(input bit_len_t len);
        if (len >= 7'd64) begin
            return '1;
        end
        return (64'd1 << len) - 64'd1;
    endfunction

    // split a bit stream into sequencer chunks of at most 64 bits
    function automatic void expected_chunks(input byte_t bytes[$], input int bits,
                                            input logic [3:0] op, output chunk_t chunks[$]);
        int     left;
        int     pos;
        chunk_t c;
        chunks.delete();
        left = bits;
        pos  = 0;
        while (left > 0) begin
            c.op   = op;
            c.len  = (left >= 64) ? 7'd64 : 7'(left);
            c.data = '0;
            for (int k = 0; k < 8; k++) begin
                if (8 * k < int'(c.len)) begin
                    c.data[8*k +: 8] = bytes[pos];  // little endian
                    pos++;
                end
            end
            chunks.push_back(c);
            left -= 64;
        end
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                   input logic [63:0] got_val);
        errors++;
        $display("ERROR at %0t: %s expected %h got %h", $time, name, exp_val, got_val);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("ERROR at %0t: %s", $time, what);
    endtask

    task automatic finish_run();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input int cmd, input byte_t data);
        int n;
        dap_in_valid = 1'b1;
        dap_in_data  = data;
        n = 0;
        while (!dap_in_ready[cmd] && n < TIMEOUT_CYCLES) begin
            next_cycle();
            n++;
        end
        if (!dap_in_ready[cmd]) begin
            report_failure($sformatf("input byte for command %0d was never accepted", cmd));
            finish_run();
        end else begin
            next_cycle();  // taken on this edge
            dap_in_valid = 1'b0;
        end
    endtask

    task automatic wait_done(input int cmd, input logic level);
        int n;
        n = 0;
        while (done[cmd] != level && n < TIMEOUT_CYCLES) begin
            next_cycle();
            n++;
        end
        if (done[cmd] != level) begin
            report_failure($sformatf("done[%0d] never went to %0b", cmd, level));
            finish_run();
        end
    endtask

    task automatic check_idle();
        assert (done == '0) else report_mismatch("done", 64'd0, 64'(done));
        assert (ram_wr.en == 1'b0) else report_mismatch("ram_wr.en", 64'd0, 64'(ram_wr.en));
        assert (seq_req.valid == 1'b0) else
            report_mismatch("seq_req.valid", 64'd0, 64'(seq_req.valid));
        assert (dap_in_ready == '0) else report_mismatch("dap_in_ready", 64'd0, 64'(dap_in_ready));
    endtask

    task automatic finish_command(input int cmd);
        wait_done(cmd, 1'b1);
        assert (done == (cmd_vec_t'(1) << cmd)) else
            report_mismatch("done", 64'(cmd_vec_t'(1) << cmd), 64'(done));
        assert (packet_len == 10'd1) else report_mismatch("packet_len", 64'd1, 64'(packet_len));
        start = '0;
        next_cycle();
        assert (done[cmd] == 1'b0) else
            report_mismatch($sformatf("done[%0d]", cmd), 64'd0, 64'(done[cmd]));
        assert (exp_req_q.size() == 0) else report_failure("expected sequencer requests missing");
        assert (exp_ram_q.size() == 0) else report_failure("expected RAM write missing");
        check_idle();
    endtask

    task automatic run_sequence(input byte_t count, input logic gaps);
        byte_t  data[$];
        chunk_t chunks[$];
        int     bits;
        bits = (count == 8'd0) ? 256 : int'(count);  // count 0 is 256 bits
        for (int i = 0; i < (bits + 7) / 8; i++) begin
            data.push_back(byte_t'($random(seed)));
        end
        expected_chunks(data, bits, SEQ_OP_SWD_SEQ, chunks);
        foreach (chunks[i]) begin
            exp_req_q.push_back(chunks[i]);
        end
        exp_ram_q.push_back(8'h00);
        start = cmd_vec_t'(1) << CMD_SWJ_SEQUENCE;
        next_cycle();
        send_byte(CMD_SWJ_SEQUENCE, count);
        foreach (data[i]) begin
            if (gaps) begin
                repeat ($unsigned($random(seed)) % 4) next_cycle();
            end
            send_byte(CMD_SWJ_SEQUENCE, data[i]);
        end
        finish_command(CMD_SWJ_SEQUENCE);
    endtask

    task automatic run_pins();
        byte_t  data[$];
        chunk_t chunks[$];
        for (int i = 0; i < 6; i++) begin
            data.push_back(byte_t'($random(seed)));
        end
        pins_reply = byte_t'($random(seed));
        expected_chunks(data, 48, SEQ_OP_SWJ_PINS, chunks);
        foreach (chunks[i]) begin
            exp_req_q.push_back(chunks[i]);
        end
        exp_ram_q.push_back(pins_reply);
        start = cmd_vec_t'(1) << CMD_SWJ_PINS;
        next_cycle();
        foreach (data[i]) begin
            send_byte(CMD_SWJ_PINS, data[i]);
        end
        finish_command(CMD_SWJ_PINS);
    endtask

    // answers each request once 1 to 8 cycles later
    initial begin : sequencer_model
        logic       pending;
        int         wait_cycles;
        logic [3:0] op;
        seq_rsp     = '0;
        pending     = 1'b0;
        wait_cycles = 0;
        op          = '0;
        forever begin
            next_cycle();
            seq_rsp.valid = 1'b0;
            if (pending) begin
                if (wait_cycles == 0) begin
                    seq_rsp.valid = 1'b1;
                    seq_rsp.flag  = '0;
                    seq_rsp.data  = {$random(seed), $random(seed)};
                    if (op == SEQ_OP_SWJ_PINS) begin
                        seq_rsp.data[7:0] = pins_reply;
                    end
                    pending = 1'b0;
                end else begin
                    wait_cycles--;
                end
            end
            if (seq_req.valid) begin
                assert (!pending) else report_failure("new request while a reply was outstanding");
                pending     = 1'b1;
                op          = seq_req.cmd[15:12];
                wait_cycles = int'($unsigned($random(seed)) % 8);
            end
        end
    end

    initial begin : output_checker
        chunk_t  exp_c;
        byte_t   exp_b;
        word64_t mask;
        forever begin
            @(negedge clk);
            if (resetn && seq_req.valid) begin
                assert (exp_req_q.size() > 0) else
                    report_failure("sequencer request that no command asked for");
                if (exp_req_q.size() > 0) begin
                    exp_c = exp_req_q.pop_front();
                    mask  = len_mask(exp_c.len);  // bits above length are stale
                    assert (seq_req.cmd[15:12] == exp_c.op) else
                        report_mismatch("seq_req.cmd opcode", 64'(exp_c.op),
                                        64'(seq_req.cmd[15:12]));
                    assert (seq_req.cmd[6:0] == exp_c.len) else
                        report_mismatch("seq_req.cmd length", 64'(exp_c.len),
                                        64'(seq_req.cmd[6:0]));
                    assert ((seq_req.data & mask) == (exp_c.data & mask)) else
                        report_mismatch("seq_req.data", exp_c.data & mask, seq_req.data & mask);
                end
            end
            if (resetn && ram_wr.en) begin
                assert (exp_ram_q.size() > 0) else report_failure("RAM write that was not expected");
                if (exp_ram_q.size() > 0) begin
                    exp_b = exp_ram_q.pop_front();
                    assert (ram_wr.addr == '0) else
                        report_mismatch("ram_wr.addr", 64'd0, 64'(ram_wr.addr));
                    assert (ram_wr.data == exp_b) else
                        report_mismatch("ram_wr.data", 64'(exp_b), 64'(ram_wr.data));
                end
            end
        end
    end

    initial begin : main
        resetn       = 1'b0;
        start        = '0;
        dap_in_valid = 1'b0;
        dap_in_data  = '0;
        pins_reply   = '0;
        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;
        next_cycle();
        check_idle();
        run_sequence(8'd8, 1'b0);
        run_sequence(8'd0, 1'b0);
        run_sequence(8'd100, 1'b1);
        run_pins();
        run_pins();  // back to back with the same result
        run_sequence(8'd8, 1'b1);
        repeat (4) next_cycle();
        finish_run();
    end

endmodule

// File: verilog/swj_cmd_top.sv
`timescale 1ns/10ps

module swj_cmd_top (
    input  logic               clk,
    input  logic               resetn,
    input  swj_pkg::cmd_vec_t  start,
    input  logic               dap_in_valid,
    input  swj_pkg::byte_t     dap_in_data,
    output swj_pkg::cmd_vec_t  dap_in_ready,
    output swj_pkg::seq_req_t  seq_req,
    input  swj_pkg::seq_rsp_t  seq_rsp,
    output swj_pkg::ram_wr_t   ram_wr,
    output swj_pkg::ram_addr_t packet_len,
    output swj_pkg::cmd_vec_t  done
);
    import swj_pkg::*;

    logic      pack_load;
    bit_len_t  pack_bit_len;
    logic      pack_ready;
    logic      pack_full;
    word64_t   pack_word;
    resp_req_t resp_req;

    swj_byte_packer packer_i (
        .clk      (clk),
        .resetn   (resetn),
        .load     (pack_load),
        .bit_len  (pack_bit_len),
        .in_valid (dap_in_valid),
        .in_data  (dap_in_data),
        .ready    (pack_ready),
        .full     (pack_full),
        .word     (pack_word)
    );

    swj_cmd_ctrl ctrl_i (
        .clk          (clk),
        .resetn       (resetn),
        .start        (start),
        .dap_in_valid (dap_in_valid),
        .dap_in_data  (dap_in_data),
        .dap_in_ready (dap_in_ready),
        .pack_load    (pack_load),
        .pack_bit_len (pack_bit_len),
        .pack_ready   (pack_ready),
        .pack_full    (pack_full),
        .pack_word    (pack_word),
        .seq_req      (seq_req),
        .seq_rsp      (seq_rsp),
        .resp_req     (resp_req)
    );

    swj_resp_writer writer_i (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .resp_req   (resp_req),
        .ram_wr     (ram_wr),
        .packet_len (packet_len),
        .done       (done)
    );

endmodule

// File: verilog/swj_cmd_ctrl.sv
`timescale 1ns/10ps

module swj_cmd_ctrl (
    input  logic               clk,
    input  logic               resetn,
    input  swj_pkg::cmd_vec_t  start,
    input  logic               dap_in_valid,
    input  swj_pkg::byte_t     dap_in_data,
    output swj_pkg::cmd_vec_t  dap_in_ready,
    output logic               pack_load,
    output swj_pkg::bit_len_t  pack_bit_len,
    input  logic               pack_ready,
    input  logic               pack_full,
    input  swj_pkg::word64_t   pack_word,
    output swj_pkg::seq_req_t  seq_req,
    input  swj_pkg::seq_rsp_t  seq_rsp,
    output swj_pkg::resp_req_t resp_req
);
    import swj_pkg::*;

    typedef enum logic [1:0] {
        SEQ_COUNT,
        SEQ_PACK,
        SEQ_WAIT,
        SEQ_END
    } seq_state_t;

    typedef enum logic [1:0] {
        PINS_LOAD,
        PINS_PACK,
        PINS_WAIT,
        PINS_END
    } pins_state_t;

    seq_state_t  seq_state;
    pins_state_t pins_state;
    seq_bits_t   seq_bits;       // bits not yet issued
    seq_bits_t   seq_bits_next;
    seq_bits_t   count_bits;
    logic        seq_issue;
    logic        seq_last;
    logic        pins_issue;
    logic        pins_reply;
    logic        req_valid;
    seq_cmd_t    req_cmd;
    word64_t     req_data;
    logic        resp_valid;
    cmd_vec_t    resp_cmd;
    byte_t       resp_data;

    function automatic bit_len_t chunk_len(input seq_bits_t bits);
        if (bits >= seq_bits_t'(MAX_CHUNK_BITS)) begin
            return MAX_CHUNK_BITS;
        end
        return bits[6:0];
    endfunction

    assign count_bits = (dap_in_data == 8'd0) ? ZERO_COUNT_BITS : seq_bits_t'(dap_in_data);
    assign seq_bits_next = (seq_bits > seq_bits_t'(MAX_CHUNK_BITS)) ?
                           seq_bits - seq_bits_t'(MAX_CHUNK_BITS) : '0;

    assign seq_issue  = start[CMD_SWJ_SEQUENCE] && seq_state == SEQ_PACK && pack_full;
    assign seq_last   = start[CMD_SWJ_SEQUENCE] && seq_state == SEQ_WAIT && seq_rsp.valid &&
                        seq_bits == '0;
    assign pins_issue = start[CMD_SWJ_PINS] && pins_state == PINS_PACK && pack_full;
    assign pins_reply = start[CMD_SWJ_PINS] && pins_state == PINS_WAIT && seq_rsp.valid;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            seq_state    <= SEQ_COUNT;
            pins_state   <= PINS_LOAD;
            seq_bits     <= '0;
            pack_load    <= 1'b0;
            pack_bit_len <= '0;
            req_valid    <= 1'b0;
            resp_valid   <= 1'b0;
        end else begin
            pack_load  <= 1'b0;
            req_valid  <= 1'b0;
            resp_valid <= 1'b0;

            if (!start[CMD_SWJ_SEQUENCE]) begin
                seq_state <= SEQ_COUNT;
            end else begin
                case (seq_state)
                    SEQ_COUNT: begin
                        if (dap_in_valid) begin
                            seq_bits     <= count_bits;
                            pack_bit_len <= chunk_len(count_bits);
                            pack_load    <= 1'b1;
                            seq_state    <= SEQ_PACK;
                        end
                    end
                    SEQ_PACK: begin
                        if (seq_issue) begin
                            req_valid <= 1'b1;
                            seq_bits  <= seq_bits_next;
                            if (seq_bits_next != '0) begin  // pack next chunk during flight
                                pack_bit_len <= chunk_len(seq_bits_next);
                                pack_load    <= 1'b1;
                            end
                            seq_state <= SEQ_WAIT;
                        end
                    end
                    SEQ_WAIT: begin
                        if (seq_rsp.valid) begin
                            if (seq_last) begin
                                resp_valid <= 1'b1;
                                seq_state  <= SEQ_END;
                            end else begin
                                seq_state <= SEQ_PACK;
                            end
                        end
                    end
                    default: ;  // hold until start falls
                endcase
            end

            if (!start[CMD_SWJ_PINS]) begin
                pins_state <= PINS_LOAD;
            end else begin
                case (pins_state)
                    PINS_LOAD: begin
                        pack_bit_len <= PINS_BITS;
                        pack_load    <= 1'b1;
                        pins_state   <= PINS_PACK;
                    end
                    PINS_PACK: begin
                        if (pins_issue) begin
                            req_valid  <= 1'b1;
                            pins_state <= PINS_WAIT;
                        end
                    end
                    PINS_WAIT: begin
                        if (pins_reply) begin
                            resp_valid <= 1'b1;
                            pins_state <= PINS_END;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (seq_issue) begin
            req_cmd  <= {SEQ_OP_SWD_SEQ, 5'd0, pack_bit_len};
            req_data <= pack_word;
        end else if (pins_issue) begin
            req_cmd  <= {SEQ_OP_SWJ_PINS, 5'd0, pack_bit_len};
            req_data <= pack_word;
        end

        if (seq_last) begin
            resp_cmd  <= cmd_vec_t'(1) << CMD_SWJ_SEQUENCE;
            resp_data <= 8'd0;  // status ok
        end else if (pins_reply) begin
            resp_cmd  <= cmd_vec_t'(1) << CMD_SWJ_PINS;
            resp_data <= seq_rsp.data[7:0];  // pin readback
        end
    end

    assign seq_req  = '{valid: req_valid, cmd: req_cmd, data: req_data};
    assign resp_req = '{valid: resp_valid, cmd: resp_cmd, data: resp_data};

    assign dap_in_ready[CMD_SWJ_SEQUENCE] = start[CMD_SWJ_SEQUENCE] &&
                                            (seq_state == SEQ_COUNT || pack_ready);
    assign dap_in_ready[CMD_SWJ_PINS]     = start[CMD_SWJ_PINS] && pack_ready;

    // the two machines share the packer
    a_start_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(start));

endmodule

// File: verilog/swj_resp_writer.sv
`timescale 1ns/10ps

module swj_resp_writer (
    input  logic               clk,
    input  logic               resetn,
    input  swj_pkg::cmd_vec_t  start,
    input  swj_pkg::resp_req_t resp_req,
    output swj_pkg::ram_wr_t   ram_wr,
    output swj_pkg::ram_addr_t packet_len,
    output swj_pkg::cmd_vec_t  done
);
    import swj_pkg::*;

    logic     wr_en;
    byte_t    wr_data;
    cmd_vec_t done_set;

    assign done_set = resp_req.valid ? resp_req.cmd : '0;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wr_en      <= 1'b0;
            packet_len <= '0;
            done       <= '0;
        end else begin
            wr_en <= resp_req.valid;
            if (resp_req.valid) begin
                packet_len <= ram_addr_t'(1);  // single status byte
            end
            done <= (done | done_set) & start;  // drops once start is gone
        end
    end

    always_ff @(posedge clk) begin
        if (resp_req.valid) begin
            wr_data <= resp_req.data;
        end
    end

    assign ram_wr = '{en: wr_en, addr: ram_addr_t'(0), data: wr_data};

    // one byte per command, so never a back to back write
    a_wr_single: assert property (@(posedge clk) disable iff (!resetn)
        wr_en |=> !wr_en);

endmodule

// File: verilog/swj_byte_packer.sv
`timescale 1ns/10ps

module swj_byte_packer (
    input  logic              clk,
    input  logic              resetn,
    input  logic              load,
    input  swj_pkg::bit_len_t bit_len,
    input  logic              in_valid,
    input  swj_pkg::byte_t    in_data,
    output logic              ready,
    output logic              full,
    output swj_pkg::word64_t  word
);
    import swj_pkg::*;

    byte_t      byte_q [8];
    logic [3:0] byte_idx;
    logic       full_q;
    logic [3:0] wr_idx;
    logic [3:0] wr_idx_next;
    logic [3:0] bytes_needed;
    logic       accept;

    assign wr_idx       = load ? 4'd0 : byte_idx;  // load restarts at byte 0
    assign wr_idx_next  = wr_idx + 4'd1;
    assign bytes_needed = 4'((8'(bit_len) + 8'd7) >> 3);

    assign ready  = !full_q || load;
    assign full   = full_q && !load;  // stale flag hidden during reload
    assign accept = in_valid && ready;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            full_q   <= 1'b1;  // nothing wanted until first load
            byte_idx <= 4'd0;
        end else if (accept) begin
            byte_idx <= wr_idx_next;
            full_q   <= (wr_idx_next >= bytes_needed);
        end else if (load) begin
            byte_idx <= 4'd0;
            full_q   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            byte_q[wr_idx[2:0]] <= in_data;
        end
    end

    // byte k at bits 8k+7:8k
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            word[8*k +: 8] = byte_q[k];
        end
    end

    // accepted byte stays within the requested length
    a_byte_in_len: assert property (@(posedge clk) disable iff (!resetn)
        accept |-> wr_idx < bytes_needed);

endmodule

// File: verilog/swj_pkg.sv
package swj_pkg;

    localparam int CMD_SWJ_SEQUENCE = 0;
    localparam int CMD_SWJ_PINS     = 1;
    localparam int CMD_COUNT        = 2;

    typedef logic [CMD_COUNT-1:0] cmd_vec_t;   // one bit per command
    typedef logic [7:0]           byte_t;
    typedef logic [63:0]          word64_t;
    typedef logic [6:0]           bit_len_t;   // 1..64
    typedef logic [8:0]           seq_bits_t;  // up to 256
    typedef logic [9:0]           ram_addr_t;
    typedef logic [15:0]          seq_cmd_t;   // opcode in [15:12], length in [6:0]

    localparam logic [3:0] SEQ_OP_SWD_SEQ  = 4'h1;
    localparam logic [3:0] SEQ_OP_SWJ_PINS = 4'h3;

    localparam bit_len_t  PINS_BITS       = 7'd48;
    localparam bit_len_t  MAX_CHUNK_BITS  = 7'd64;
    localparam seq_bits_t ZERO_COUNT_BITS = 9'd256;  // count byte 0

    // request to the serial sequencer
    typedef struct packed {
        logic     valid;
        seq_cmd_t cmd;
        word64_t  data;
    } seq_req_t;

    // reply from the serial sequencer
    typedef struct packed {
        logic        valid;
        logic [15:0] flag;
        word64_t     data;
    } seq_rsp_t;

    // one response byte, tagged with its command
    typedef struct packed {
        logic     valid;
        cmd_vec_t cmd;     // one-hot
        byte_t    data;
    } resp_req_t;

    // response RAM write port
    typedef struct packed {
        logic      en;
        ram_addr_t addr;
        byte_t     data;
    } ram_wr_t;

endpackage
